// File: Bender.yml
package:
  name: dbus_subsystem

sources:
  - include_dirs:
      - src
    files:
      - src/dbus_pkg.sv
      - src/periph_pkg.sv
      - src/dbus_interconnect.sv
      - src/data_mem.sv
      - src/uart_regs.sv
      - src/uart_tx.sv
      - src/clint_timer.sv
      - src/dbus_subsystem.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/dbus_subsystem_tb.sv

// File: dbus_subsystem.f
+incdir+src
src/dbus_pkg.sv
src/periph_pkg.sv
src/dbus_interconnect.sv
src/data_mem.sv
src/uart_regs.sv
src/uart_tx.sv
src/clint_timer.sv
src/dbus_subsystem.sv
tb/dbus_subsystem_tb.sv

// File: src/clint_timer.sv
module clint_timer import dbus_pkg::*, periph_pkg::*; (
   input  logic            clk,
   input  logic            reset_i,
   input  logic            sel_i,
   input  type_dbus2peri_s dbus2peri_i,
   output type_peri2dbus_s clint2dbus_o,
   output logic            timer_irq_o,
   output logic            soft_irq_o
);

   type_clint_reg_e reg_sel;
   logic            access;
   logic            wr;
   logic            ack;
   logic [31:0]     r_data;
   logic [63:0]     mtime;
   logic [63:0]     mtimecmp;

   // Merge the enabled lanes of a write into a register word
   function automatic logic [31:0] merge_bytes(input logic [31:0] cur,
                                               input logic [31:0] wdata,
                                               input logic [3:0]  mask);
      logic [31:0] res;
      res = cur;
      for (int i = 0; i < 4; i++) begin
         if (mask[i]) res[8*i +: 8] = wdata[8*i +: 8];
      end
      return res;
   endfunction

   assign reg_sel = type_clint_reg_e'(dbus2peri_i.addr[15:0]);
   assign access  = sel_i & ~ack;
   assign wr      = access & dbus2peri_i.w_en;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack         <= 1'b0;
         mtime       <= '0;
         mtimecmp    <= '1;     // No timer interrupt out of reset
         soft_irq_o  <= 1'b0;
         timer_irq_o <= 1'b0;
      end else begin
         ack         <= access;
         timer_irq_o <= (mtime >= mtimecmp);   // One cycle behind mtime
         // A write to mtime takes the place of the increment
         if (wr && reg_sel == MTIME_LO) begin
            mtime[31:0] <= merge_bytes(mtime[31:0], dbus2peri_i.w_data, dbus2peri_i.sel_byte);
         end else if (wr && reg_sel == MTIME_HI) begin
            mtime[63:32] <= merge_bytes(mtime[63:32], dbus2peri_i.w_data, dbus2peri_i.sel_byte);
         end else begin
            mtime <= mtime + 64'd1;
         end
         if (wr && reg_sel == MTIMECMP_LO) begin
            mtimecmp[31:0] <= merge_bytes(mtimecmp[31:0], dbus2peri_i.w_data,
                                          dbus2peri_i.sel_byte);
         end
         if (wr && reg_sel == MTIMECMP_HI) begin
            mtimecmp[63:32] <= merge_bytes(mtimecmp[63:32], dbus2peri_i.w_data,
                                           dbus2peri_i.sel_byte);
         end
         if (wr && reg_sel == MSIP && dbus2peri_i.sel_byte[0]) soft_irq_o <= dbus2peri_i.w_data[0];
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            MSIP:        r_data <= {31'b0, soft_irq_o};
            MTIMECMP_LO: r_data <= mtimecmp[31:0];
            MTIMECMP_HI: r_data <= mtimecmp[63:32];
            MTIME_LO:    r_data <= mtime[31:0];
            MTIME_HI:    r_data <= mtime[63:32];
            default:     r_data <= '0;
         endcase
      end
   end

   assign clint2dbus_o.r_data = r_data;
   assign clint2dbus_o.ack    = ack;

endmodule : clint_timer

// File: src/data_mem.sv
`include "dbus_config.svh"

module data_mem import dbus_pkg::*; (
   input  logic            clk,
   input  logic            reset_i,
   input  logic            sel_i,
   input  type_dbus2peri_s dbus2peri_i,
   output type_peri2dbus_s dmem2dbus_o
);

   localparam int DMEM_AW = $clog2(`DMEM_DEPTH);

   logic [31:0]        mem [`DMEM_DEPTH];
   logic [DMEM_AW-1:0] word_idx;
   logic               access;
   logic               ack;
   logic [31:0]        r_data;

   assign word_idx = dbus2peri_i.addr[DMEM_AW+1:2];   // Drop byte offset
   assign access   = sel_i & ~ack;                    // First cycle of a request

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   // Byte enabled write
   always_ff @(posedge clk) begin
      if (access && dbus2peri_i.w_en) begin
         for (int i = 0; i < 4; i++) begin
            if (dbus2peri_i.sel_byte[i]) begin
               mem[word_idx][8*i +: 8] <= dbus2peri_i.w_data[8*i +: 8];
            end
         end
      end
   end

   // Read word lines up with ack
   always_ff @(posedge clk) begin
      if (access) begin
         r_data <= mem[word_idx];
      end
   end

   assign dmem2dbus_o.r_data = r_data;
   assign dmem2dbus_o.ack    = ack;

endmodule : data_mem

// File: src/dbus_config.svh
`ifndef DBUS_CONFIG_SVH
`define DBUS_CONFIG_SVH

// Data bus address width
`define DBUS_ADDR_WIDTH    32

// Device select field in the top nibble
`define DEV_SEL_ADDR_HIGH  31
`define DEV_SEL_ADDR_LOW   28

// Device field values for each slave
`define DMEM_ADDR_MATCH    4'h8
`define UART_ADDR_MATCH    4'h9
`define CLINT_ADDR_MATCH   4'h2

// Data memory size in 32-bit words
`define DMEM_DEPTH         256

// UART baud divisor after reset, in clock cycles per bit
`define UART_DIV_RESET     16'd16

`endif // DBUS_CONFIG_SVH

// File: src/dbus_interconnect.sv
`include "dbus_config.svh"

module dbus_interconnect import dbus_pkg::*; (
   input  logic            clk,
   input  logic            reset_i,
   input  type_lsu2dbus_s  lsu2dbus_i,
   output type_dbus2lsu_s  dbus2lsu_o,     // Response to the LSU
   input  type_peri2dbus_s dmem2dbus_i,
   input  type_peri2dbus_s uart2dbus_i,
   input  type_peri2dbus_s clint2dbus_i,
   output logic            dmem_sel_o,
   output logic            uart_sel_o,
   output logic            clint_sel_o,
   output type_dbus2peri_s dbus2peri_o     // Shared request to all slaves
);

   logic [`DBUS_ADDR_WIDTH-1:0] bus_addr;
   logic [3:0]                  dev_field;
   logic                        bus_req;
   logic                        dmem_sel;
   logic                        uart_sel;
   logic                        clint_sel;
   logic [31:0]                 lane_data;
   logic [3:0]                  lane_mask;

   assign bus_addr  = lsu2dbus_i.addr;
   assign dev_field = bus_addr[`DEV_SEL_ADDR_HIGH:`DEV_SEL_ADDR_LOW];
   assign bus_req   = lsu2dbus_i.ld_req | lsu2dbus_i.st_req;

   // Store data moved to the lanes picked by the low address bits
   always_comb begin
      lane_data = '0;
      lane_mask = 4'b0000;
      case (lsu2dbus_i.st_ops)
         ST_OPS_SB: begin
            lane_data[8*bus_addr[1:0] +: 8] = lsu2dbus_i.w_data[7:0];
            lane_mask[bus_addr[1:0]]        = 1'b1;
         end
         ST_OPS_SH: begin
            if (bus_addr[1]) begin
               lane_data[31:16] = lsu2dbus_i.w_data[15:0];
               lane_mask        = 4'b1100;
            end else begin
               lane_data[15:0] = lsu2dbus_i.w_data[15:0];
               lane_mask       = 4'b0011;
            end
         end
         ST_OPS_SW: begin
            lane_data = lsu2dbus_i.w_data;
            lane_mask = 4'b1111;
         end
         default: begin   // Loads carry no mask
            lane_data = '0;
            lane_mask = 4'b0000;
         end
      endcase
   end

   // Device decode, dmem first then clint then uart
   always_comb begin
      dmem_sel  = 1'b0;
      clint_sel = 1'b0;
      uart_sel  = 1'b0;
      if (bus_req) begin
         if (dev_field == `DMEM_ADDR_MATCH) begin
            dmem_sel = 1'b1;
         end else if (dev_field == `CLINT_ADDR_MATCH) begin
            clint_sel = 1'b1;
         end else if (dev_field == `UART_ADDR_MATCH) begin
            uart_sel = 1'b1;
         end
      end
   end

   assign dbus2peri_o.addr     = bus_addr;
   assign dbus2peri_o.w_data   = lane_data;
   assign dbus2peri_o.sel_byte = lane_mask;
   assign dbus2peri_o.w_en     = lsu2dbus_i.st_req;

   assign dmem_sel_o  = dmem_sel;
   assign uart_sel_o  = uart_sel;
   assign clint_sel_o = clint_sel;

   // Unmapped or idle returns all zeros, so no ack
   always_comb begin
      if (dmem_sel) begin
         dbus2lsu_o = type_dbus2lsu_s'(dmem2dbus_i);
      end else if (clint_sel) begin
         dbus2lsu_o = type_dbus2lsu_s'(clint2dbus_i);
      end else if (uart_sel) begin
         dbus2lsu_o = type_dbus2lsu_s'(uart2dbus_i);
      end else begin
         dbus2lsu_o = '0;
      end
   end

endmodule : dbus_interconnect

// File: src/dbus_pkg.sv
`include "dbus_config.svh"

package dbus_pkg;

   // Store width requested by the LSU
   typedef enum logic [1:0] {
      ST_OPS_NONE = 2'b00,
      ST_OPS_SB   = 2'b01,
      ST_OPS_SH   = 2'b10,
      ST_OPS_SW   = 2'b11
   } type_st_ops_e;

   // LSU request, store data still right aligned
   typedef struct packed {
      logic [`DBUS_ADDR_WIDTH-1:0] addr;
      logic [31:0]                 w_data;
      type_st_ops_e                st_ops;
      logic                        ld_req;
      logic                        st_req;
   } type_lsu2dbus_s;

   // Request as seen by every slave
   typedef struct packed {
      logic [`DBUS_ADDR_WIDTH-1:0] addr;
      logic [31:0]                 w_data;   // Lane placed
      logic [3:0]                  sel_byte;
      logic                        w_en;
   } type_dbus2peri_s;

   typedef struct packed {
      logic [31:0] r_data;
      logic        ack;
   } type_peri2dbus_s;

   // Core side response, same layout as the slave response
   typedef struct packed {
      logic [31:0] r_data;
      logic        ack;
   } type_dbus2lsu_s;

endpackage : dbus_pkg

// File: src/dbus_subsystem.sv
module dbus_subsystem import dbus_pkg::*; (
   input  logic           clk,
   input  logic           reset_i,
   input  type_lsu2dbus_s lsu2dbus_i,
   output type_dbus2lsu_s dbus2lsu_o,
   output logic           uart_tx_o,     // Serial line out
   output logic           timer_irq_o,
   output logic           soft_irq_o
);

   type_dbus2peri_s dbus2peri;
   type_peri2dbus_s dmem2dbus;
   type_peri2dbus_s uart2dbus;
   type_peri2dbus_s clint2dbus;
   logic            dmem_sel;
   logic            uart_sel;
   logic            clint_sel;

   // UART register block to transmitter
   logic            tx_start;
   logic [7:0]      tx_data;
   logic [15:0]     tx_divisor;
   logic            tx_busy;

   dbus_interconnect u_dbus_interconnect (
      .clk          (clk),
      .reset_i      (reset_i),
      .lsu2dbus_i   (lsu2dbus_i),
      .dbus2lsu_o   (dbus2lsu_o),
      .dmem2dbus_i  (dmem2dbus),
      .uart2dbus_i  (uart2dbus),
      .clint2dbus_i (clint2dbus),
      .dmem_sel_o   (dmem_sel),
      .uart_sel_o   (uart_sel),
      .clint_sel_o  (clint_sel),
      .dbus2peri_o  (dbus2peri)
   );

   data_mem u_data_mem (
      .clk         (clk),
      .reset_i     (reset_i),
      .sel_i       (dmem_sel),
      .dbus2peri_i (dbus2peri),
      .dmem2dbus_o (dmem2dbus)
   );

   uart_regs u_uart_regs (
      .clk         (clk),
      .reset_i     (reset_i),
      .sel_i       (uart_sel),
      .dbus2peri_i (dbus2peri),
      .uart2dbus_o (uart2dbus),
      .busy_i      (tx_busy),
      .tx_start_o  (tx_start),
      .tx_data_o   (tx_data),
      .divisor_o   (tx_divisor)
   );

   uart_tx u_uart_tx (
      .clk       (clk),
      .reset_i   (reset_i),
      .start_i   (tx_start),
      .data_i    (tx_data),
      .divisor_i (tx_divisor),
      .busy_o    (tx_busy),
      .tx_o      (uart_tx_o)
   );

   clint_timer u_clint_timer (
      .clk          (clk),
      .reset_i      (reset_i),
      .sel_i        (clint_sel),
      .dbus2peri_i  (dbus2peri),
      .clint2dbus_o (clint2dbus),
      .timer_irq_o  (timer_irq_o),
      .soft_irq_o   (soft_irq_o)
   );

endmodule : dbus_subsystem

// File: src/periph_pkg.sv
package periph_pkg;

   // UART register offsets, low address nibble
   typedef enum logic [3:0] {
      TXDATA  = 4'h0,
      STATUS  = 4'h4,
      DIVISOR = 4'h8
   } type_uart_reg_e;

   // CLINT register offsets, low 16 address bits
   typedef enum logic [15:0] {
      MSIP        = 16'h0000,
      MTIMECMP_LO = 16'h4000,
      MTIMECMP_HI = 16'h4004,
      MTIME_LO    = 16'hBFF8,
      MTIME_HI    = 16'hBFFC
   } type_clint_reg_e;

   // 8N1 transmitter states
   typedef enum logic [1:0] {
      IDLE  = 2'b00,
      START = 2'b01,
      DATA  = 2'b10,
      STOP  = 2'b11
   } type_uart_tx_state_e;

endpackage : periph_pkg

// File: src/uart_regs.sv
`include "dbus_config.svh"

module uart_regs import dbus_pkg::*, periph_pkg::*; (
   input  logic            clk,
   input  logic            reset_i,
   input  logic            sel_i,
   input  type_dbus2peri_s dbus2peri_i,
   output type_peri2dbus_s uart2dbus_o,
   input  logic            busy_i,
   output logic            tx_start_o,
   output logic [7:0]      tx_data_o,
   output logic [15:0]     divisor_o
);

   type_uart_reg_e reg_sel;
   logic           access;
   logic           wr;
   logic           ack;
   logic [31:0]    r_data;

   assign reg_sel = type_uart_reg_e'(dbus2peri_i.addr[3:0]);
   assign access  = sel_i & ~ack;
   assign wr      = access & dbus2peri_i.w_en;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack        <= 1'b0;
         tx_start_o <= 1'b0;
         divisor_o  <= `UART_DIV_RESET;
      end else begin
         ack        <= access;
         tx_start_o <= wr & (reg_sel == TXDATA) & ~busy_i;   // Dropped while busy
         if (wr && reg_sel == DIVISOR) begin
            if (dbus2peri_i.sel_byte[0]) divisor_o[7:0]  <= dbus2peri_i.w_data[7:0];
            if (dbus2peri_i.sel_byte[1]) divisor_o[15:8] <= dbus2peri_i.w_data[15:8];
         end
      end
   end

   // Byte handed to the transmitter
   always_ff @(posedge clk) begin
      if (wr && reg_sel == TXDATA && !busy_i) tx_data_o <= dbus2peri_i.w_data[7:0];
   end

   always_ff @(posedge clk) begin
      if (access) begin
         case (reg_sel)
            TXDATA:  r_data <= {24'b0, tx_data_o};
            STATUS:  r_data <= {31'b0, busy_i};
            DIVISOR: r_data <= {16'b0, divisor_o};
            default: r_data <= '0;
         endcase
      end
   end

   assign uart2dbus_o.r_data = r_data;
   assign uart2dbus_o.ack    = ack;

endmodule : uart_regs

// File: src/uart_tx.sv
module uart_tx import periph_pkg::*; (
   input  logic        clk,
   input  logic        reset_i,
   input  logic        start_i,
   input  logic [7:0]  data_i,
   input  logic [15:0] divisor_i,
   output logic        busy_o,
   output logic        tx_o
);

   type_uart_tx_state_e state;
   logic [15:0]         baud_cnt;
   logic [15:0]         div_q;      // Divisor held for the whole frame
   logic [2:0]          bit_cnt;
   logic [7:0]          shift;
   logic                bit_done;

   assign bit_done = (baud_cnt == div_q - 16'd1);
   assign busy_o   = (state != IDLE);

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state    <= IDLE;
         tx_o     <= 1'b1;   // Line idles high
         baud_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         baud_cnt <= bit_done ? '0 : baud_cnt + 16'd1;
         case (state)
            IDLE: begin
               baud_cnt <= '0;
               if (start_i) begin
                  state <= START;
                  tx_o  <= 1'b0;   // Start bit
               end
            end
            START: if (bit_done) begin
               state   <= DATA;
               bit_cnt <= '0;
               tx_o    <= shift[0];   // LSB first
            end
            DATA: if (bit_done) begin
               if (bit_cnt == 3'd7) begin
                  state <= STOP;
                  tx_o  <= 1'b1;
               end else begin
                  bit_cnt <= bit_cnt + 3'd1;
                  tx_o    <= shift[1];
               end
            end
            STOP: if (bit_done) state <= IDLE;
            default: state <= IDLE;
         endcase
      end
   end

   // Frame payload, loaded on start and shifted per data bit
   always_ff @(posedge clk) begin
      if (state == IDLE && start_i) begin
         shift <= data_i;
         div_q <= divisor_i;
      end else if (state == DATA && bit_done) begin
         shift <= shift >> 1;
      end
   end

endmodule : uart_tx

// File: tb/dbus_subsystem_tb.sv
`include "dbus_config.svh"

module dbus_subsystem_tb import dbus_pkg::*; ();

   // One trace line
   typedef struct packed {
      logic [7:0]  kind;      // S store, L load, U UART frame, I interrupt wait
      logic [31:0] addr;
      logic [31:0] data;
      logic [1:0]  ops;
      logic [31:0] exp_val;
   } trace_entry_s;

   logic           clk;
   logic           reset_i;
   type_lsu2dbus_s lsu2dbus;
   type_dbus2lsu_s dbus2lsu;
   logic           uart_tx;
   logic           timer_irq;
   logic           soft_irq;

   trace_entry_s   trace_q[$];
   logic [7:0]     mem_model [logic [31:0]];   // Byte address to byte
   logic [7:0]     frame_q[$];                 // Bytes recovered from the serial line
   int             errors;
   int             failed_tests;
   int             divisor;

   dbus_subsystem uut (
      .clk         (clk),
      .reset_i     (reset_i),
      .lsu2dbus_i  (lsu2dbus),
      .dbus2lsu_o  (dbus2lsu),
      .uart_tx_o   (uart_tx),
      .timer_irq_o (timer_irq),
      .soft_irq_o  (soft_irq)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic bit is_dmem(input logic [31:0] addr);
      return addr[`DEV_SEL_ADDR_HIGH:`DEV_SEL_ADDR_LOW] == `DMEM_ADDR_MATCH;
   endfunction

   function automatic bit is_mapped(input logic [31:0] addr);
      logic [3:0] dev;
      dev = addr[`DEV_SEL_ADDR_HIGH:`DEV_SEL_ADDR_LOW];
      return dev == `DMEM_ADDR_MATCH || dev == `UART_ADDR_MATCH || dev == `CLINT_ADDR_MATCH;
   endfunction

   // New divisor if this line writes the UART DIVISOR register
   function automatic int divisor_after(input trace_entry_s op, input int cur);
      if (op.kind == "S" && op.addr == {`UART_ADDR_MATCH, 28'h0000008}) return op.data[15:0];
      return cur;
   endfunction

   // Lane rule: byte at its address, half on an even pair, word on the aligned four
   task automatic store_to_model(input trace_entry_s op);
      case (op.ops)
         2'd1: mem_model[op.addr] = op.data[7:0];
         2'd2: begin
            for (int i = 0; i < 2; i++) begin
               mem_model[{op.addr[31:1], 1'b0} + i] = op.data[8*i +: 8];
            end
         end
         default: begin
            for (int i = 0; i < 4; i++) begin
               mem_model[{op.addr[31:2], 2'b00} + i] = op.data[8*i +: 8];
            end
         end
      endcase
   endtask

   function automatic logic [31:0] expected_word(input logic [31:0] addr);
      logic [31:0] word;
      for (int i = 0; i < 4; i++) begin
         word[8*i +: 8] = mem_model[{addr[31:2], 2'b00} + i];
      end
      return word;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                  input logic [31:0] act_val);
      $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp_val, act_val);
      errors++;
   endtask

   task automatic bus_access(input trace_entry_s op);
      logic [31:0] exp_val;
      @(posedge clk);
      #2;
      lsu2dbus.addr   = op.addr;
      lsu2dbus.w_data = op.data;
      lsu2dbus.st_ops = type_st_ops_e'(op.ops);
      lsu2dbus.ld_req = (op.kind == "L");
      lsu2dbus.st_req = (op.kind == "S");
      if (!is_mapped(op.addr)) begin
         repeat (4) begin   // Nobody may answer
            @(posedge clk);
            #2;
            if (dbus2lsu.ack !== 1'b0) report_mismatch("dbus2lsu_o.ack", 0, dbus2lsu.ack);
            if (dbus2lsu.r_data !== '0) report_mismatch("dbus2lsu_o.r_data", 0, dbus2lsu.r_data);
         end
      end else begin
         @(posedge clk);
         #2;
         if (dbus2lsu.ack !== 1'b1) begin
            report_mismatch("dbus2lsu_o.ack", 1, dbus2lsu.ack);
         end else if (op.kind == "L") begin
            exp_val = is_dmem(op.addr) ? expected_word(op.addr) : op.exp_val;
            if (dbus2lsu.r_data !== exp_val) begin
               report_mismatch("dbus2lsu_o.r_data", exp_val, dbus2lsu.r_data);
            end
         end
         if (op.kind == "S" && is_dmem(op.addr)) store_to_model(op);
         divisor = divisor_after(op, divisor);
      end
      lsu2dbus = '0;
   endtask

   task automatic uart_frame_check(input trace_entry_s op);
      int         waited;
      logic [7:0] rx;
      waited = 0;
      while (frame_q.size() == 0 && waited < 12 * divisor) begin
         @(posedge clk);
         #2;
         waited++;
      end
      if (frame_q.size() == 0) begin
         $display("No UART frame arrived within %0d cycles", 12 * divisor);
         errors++;
      end else begin
         rx = frame_q.pop_front();
         if (rx !== op.exp_val[7:0]) report_mismatch("uart_tx_o byte", op.exp_val, rx);
      end
   endtask

   // addr bit 0 picks the soft interrupt, data is the cycle limit
   task automatic irq_wait(input trace_entry_s op);
      int   waited;
      logic level;
      waited = 0;
      do begin
         @(posedge clk);
         #2;
         level = op.addr[0] ? soft_irq : timer_irq;
         waited++;
      end while (level !== op.exp_val[0] && waited <= op.data);
      if (level !== op.exp_val[0]) begin
         report_mismatch(op.addr[0] ? "soft_irq_o" : "timer_irq_o", op.exp_val, level);
      end
   endtask

   // Serial monitor, samples each bit in its center
   initial begin
      logic [7:0] rx_byte;
      logic       framing_ok;
      int         div;
      wait (reset_i === 1'b0);
      forever begin
         @(negedge uart_tx);
         div = divisor;
         repeat (div / 2) @(posedge clk);
         #1;
         framing_ok = (uart_tx === 1'b0);
         for (int i = 0; i < 8; i++) begin
            repeat (div) @(posedge clk);
            #1;
            rx_byte[i] = uart_tx;
         end
         repeat (div) @(posedge clk);
         #1;
         framing_ok = framing_ok && (uart_tx === 1'b1);
         repeat (div / 2) @(posedge clk);   // End of stop bit
         if (!framing_ok) begin
            $display("UART frame ending at t=%0t has a bad start or stop bit", $time);
            errors++;
         end
         frame_q.push_back(rx_byte);
      end
   end

   initial begin
      int           fd;
      int           c;
      int           n;
      int           ops_val;
      int           budget;
      int           div;
      int           errs_before;
      logic [31:0]  addr;
      logic [31:0]  data;
      logic [31:0]  exp_val;
      trace_entry_s op;
      errors       = 0;
      failed_tests = 0;
      divisor      = `UART_DIV_RESET;
      reset_i      = 1'b1;
      lsu2dbus     = '0;
      fd = $fopen("tb/dbus_trace.txt", "r");
      if (fd == 0) begin
         $display("Could not open the trace file tb/dbus_trace.txt");
         $display("Verification failed");
         $finish;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (c == "#") begin
            while (c != "\n" && c != -1) c = $fgetc(fd);
         end else if (c == "S" || c == "L" || c == "U" || c == "I") begin
            n = $fscanf(fd, "%h %h %d %h", addr, data, ops_val, exp_val);
            op.kind    = c[7:0];
            op.addr    = addr;
            op.data    = data;
            op.ops     = ops_val[1:0];
            op.exp_val = exp_val;
            if (n == 4) trace_q.push_back(op);
         end
         c = $fgetc(fd);
      end
      $fclose(fd);

      // Run length in cycles, from the trace itself
      budget = 3;
      div    = `UART_DIV_RESET;
      foreach (trace_q[i]) begin
         budget += 10;
         if (trace_q[i].kind == "U") budget += 12 * div;
         if (trace_q[i].kind == "I") budget += trace_q[i].data;
         div = divisor_after(trace_q[i], div);
      end
      fork
         begin
            repeat (budget) @(posedge clk);
            $display("Watchdog expired after %0d cycles", budget);
            $display("Verification failed");
            $finish;
         end
      join_none

      repeat (3) @(posedge clk);
      #2;
      reset_i = 1'b0;

      foreach (trace_q[i]) begin
         op          = trace_q[i];
         errs_before = errors;
         case (op.kind)
            "S", "L": bus_access(op);
            "U":      uart_frame_check(op);
            default:  irq_wait(op);
         endcase
         if (errors != errs_before) failed_tests++;
         $display("test %0d %c %h %s", i, op.kind, op.addr,
                  (errors == errs_before) ? "ok" : "failed");
      end
      if (frame_q.size() != 0) begin
         $display("%0d UART frame(s) arrived that no trace line expected", frame_q.size());
         errors++;
      end
      $display("%0d tests, %0d failed, %0d errors", trace_q.size(), failed_tests, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule : dbus_subsystem_tb

// File: tb/dbus_trace.txt
# kind addr data st_ops expect; kind S store, L load, U UART frame wait, I interrupt wait
# st_ops 0 none 1 byte 2 half 3 word; for I, addr 0 timer 1 soft, data is the cycle limit
S 80000000 11223344 3 00000000
S 80000000 000000AA 1 00000000
S 80000001 FFFFFFBB 1 00000000
S 80000002 ABCD00CC 1 00000000
S 80000003 000000DD 1 00000000
L 80000000 00000000 0 DDCCBBAA
S 80000004 00000000 3 00000000
S 80000004 1234BEEF 2 00000000
S 80000006 0000CAFE 2 00000000
L 80000004 00000000 0 CAFEBEEF
S 800003FC 12345678 3 00000000
S 800003FD 0000009A 1 00000000
L 800003FC 00000000 0 12349A78
L 80000000 00000000 0 DDCCBBAA
L 40000000 00000000 0 00000000
S 50000010 12345678 3 00000000
L 90000008 00000000 0 00000010
S 90000008 00000008 3 00000000
L 90000008 00000000 0 00000008
S 90000000 000000A5 3 00000000
L 90000004 00000000 0 00000001
S 90000000 0000003C 3 00000000
U 00000000 00000000 0 000000A5
L 90000004 00000000 0 00000000
S 2000BFFC 00000000 3 00000000
S 2000BFF8 00000100 3 00000000
S 20004000 00000120 3 00000000
S 20004004 00000000 3 00000000
I 00000000 00000000 0 00000000
I 00000000 00000023 0 00000001
L 20004000 00000000 0 00000120
L 20004004 00000000 0 00000000
S 20000000 00000001 3 00000000
I 00000001 00000000 0 00000001
S 20000000 00000000 3 00000000
I 00000001 00000000 0 00000000
